// File: logic/router_pkg.sv
/* Shared widths and the packet header layout. The header is the first word
   of every packet; port count is fixed at two. */

`default_nettype none

package router_pkg;

    ////////////////////
    // Stream and port sizing

    localparam int DATA_W    = 32;
    localparam int NUM_PORTS = 2;
    localparam int PORT_W    = 1;

    // Statistics counters
    localparam int CNT_W = 16;

    // Packet buffer, depth must equal 2**BUF_AW
    localparam int BUF_DEPTH = 16;
    localparam int BUF_AW    = 4;

    ////////////////////
    // Header word, MSB first

    typedef struct packed {
        logic [PORT_W-1:0] egr_port;
        logic [6:0]        ttl;
        logic [7:0]        len;
        logic [15:0]       flow_id;
    } pkt_hdr_t;

    // Header word or payload word, same bits
    typedef union packed {
        logic [DATA_W-1:0] raw;
        pkt_hdr_t          hdr;
    } pkt_word_u;

endpackage

`default_nettype wire

// File: logic/router_ingress.sv
/* Two-port packet arbiter. Grants switch only between packets, with one idle
   cycle per grant; output is a single register stage. */

`timescale 1ns/1ps
`default_nettype none

module router_ingress (
    input  wire                                       core_clk,
    input  wire                                       rst,

    // Ingress streams
    input  wire  [router_pkg::NUM_PORTS-1:0]          ing_valid,
    input  wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::DATA_W-1:0]             ing_data,
    input  wire  [router_pkg::NUM_PORTS-1:0]          ing_last,
    output logic [router_pkg::NUM_PORTS-1:0]          ing_ready,

    // Merged stream towards the buffer
    output logic                                      in_valid,
    output logic [router_pkg::DATA_W-1:0]             in_data,
    output logic                                      in_last,
    output logic [router_pkg::PORT_W-1:0]             in_src,
    input  wire                                       in_ready,

    // Statistics
    input  wire                                       cnt_clear,
    output logic [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::CNT_W-1:0]              ing_pkt_cnt
);

    logic                          busy;
    logic [router_pkg::PORT_W-1:0] grant;
    logic [router_pkg::PORT_W-1:0] prio;
    logic [router_pkg::PORT_W-1:0] pick;
    logic                          out_space;
    logic                          acc;

    // Output register can take a beat
    assign out_space = !in_valid || in_ready;

    // Only the granted port ever sees ready
    assign acc = |(ing_valid & ing_ready);

    ////////////////////
    // Arbitration

    // Priority port wins a tie, otherwise the other one
    always_comb begin
        if (ing_valid[prio]) begin
            pick = prio;
        end else begin
            pick = prio + 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rst) begin
            busy  <= 1'b0;
            grant <= '0;
            prio  <= '0;
        end else if (!busy) begin
            if (|ing_valid) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (acc && ing_last[grant]) begin
            // Packet done, hand priority to the other port
            busy <= 1'b0;
            prio <= grant + 1'b1;
        end
    end

    always_comb begin
        ing_ready = '0;
        if (busy) begin
            ing_ready[grant] = out_space;
        end
    end

    ////////////////////
    // Output stage

    always_ff @(posedge core_clk) begin
        if (rst) begin
            in_valid <= 1'b0;
        end else if (out_space) begin
            in_valid <= acc;
        end
    end

    always_ff @(posedge core_clk) begin
        if (acc) begin
            in_data <= ing_data[grant];
            in_last <= ing_last[grant];
            in_src  <= grant;
        end
    end

    // Accepted packets per port
    always_ff @(posedge core_clk) begin
        if (rst || cnt_clear) begin
            ing_pkt_cnt <= '0;
        end else if (acc && ing_last[grant]) begin
            ing_pkt_cnt[grant] <= ing_pkt_cnt[grant] + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/router_pkt_buffer.sv
/* First-word-fall-through FIFO of data, last and source tag. A write while
   full is accepted only together with a read. */

`timescale 1ns/1ps
`default_nettype none

module router_pkt_buffer (
    input  wire                                 core_clk,
    input  wire                                 rst,

    // Write side
    input  wire                                 in_valid,
    input  wire  [router_pkg::DATA_W-1:0]       in_data,
    input  wire                                 in_last,
    input  wire  [router_pkg::PORT_W-1:0]       in_src,
    output logic                                in_ready,

    // Read side
    output logic                                out_valid,
    output logic [router_pkg::DATA_W-1:0]       out_data,
    output logic                                out_last,
    output logic [router_pkg::PORT_W-1:0]       out_src,
    input  wire                                 out_ready
);

    // Word layout is {src, last, data}
    logic [router_pkg::DATA_W+router_pkg::PORT_W:0] mem [router_pkg::BUF_DEPTH];

    logic [router_pkg::BUF_AW-1:0] wr_ptr;
    logic [router_pkg::BUF_AW-1:0] rd_ptr;
    logic [router_pkg::BUF_AW:0]   count;
    logic                          full;
    logic                          wr;
    logic                          rd;

    assign full      = (count == router_pkg::BUF_DEPTH);
    assign out_valid = (count != '0);
    assign in_ready  = !full || out_ready;

    assign wr = in_valid && in_ready;
    assign rd = out_valid && out_ready;

    ////////////////////
    // Storage

    always_ff @(posedge core_clk) begin
        if (wr) begin
            mem[wr_ptr] <= {in_src, in_last, in_data};
        end
    end

    // Head of queue is always on the outputs
    assign {out_src, out_last, out_data} = mem[rd_ptr];

    ////////////////////
    // Pointers and fill level

    always_ff @(posedge core_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/router_egress.sv
/* Header decode and steering. The first word of every packet must be a valid
   header; the drop or forward choice holds until its last beat. */

`timescale 1ns/1ps
`default_nettype none

module router_egress (
    input  wire                                       core_clk,
    input  wire                                       rst,

    // Stream from the buffer
    input  wire                                       out_valid,
    input  wire  [router_pkg::DATA_W-1:0]             out_data,
    input  wire                                       out_last,
    input  wire  [router_pkg::PORT_W-1:0]             out_src,
    output logic                                      out_ready,

    // Egress streams
    output logic [router_pkg::NUM_PORTS-1:0]          egr_valid,
    output logic [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::DATA_W-1:0]             egr_data,
    output logic [router_pkg::NUM_PORTS-1:0]          egr_last,
    output logic [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::PORT_W-1:0]             egr_src,
    input  wire  [router_pkg::NUM_PORTS-1:0]          egr_ready,

    // Control and statistics
    input  wire  [router_pkg::NUM_PORTS-1:0]          egr_port_enable,
    input  wire                                       cnt_clear,
    output logic [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::CNT_W-1:0]              egr_pkt_cnt,
    output logic [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::CNT_W-1:0]              egr_drop_cnt
);

    router_pkg::pkt_word_u         in_word;
    router_pkg::pkt_word_u         hdr_word;
    logic                          sop;
    logic [router_pkg::PORT_W-1:0] pkt_port;
    logic                          pkt_drop;
    logic [router_pkg::PORT_W-1:0] cur_port;
    logic                          cur_drop;
    logic                          hdr_drop;
    logic                          take;

    ////////////////////
    // Decode

    always_comb begin
        in_word.raw = out_data;

        // Outgoing header with one hop used up
        hdr_word         = in_word;
        hdr_word.hdr.ttl = in_word.hdr.ttl - 1'b1;

        hdr_drop = (in_word.hdr.ttl == '0) || !egr_port_enable[in_word.hdr.egr_port];

        // Header beat decides directly, later beats use the held choice
        cur_port = sop ? in_word.hdr.egr_port : pkt_port;
        cur_drop = sop ? hdr_drop : pkt_drop;

        // Drops drain freely, forwards wait for the target register
        out_ready = cur_drop || !egr_valid[cur_port] || egr_ready[cur_port];
    end

    assign take = out_valid && out_ready;

    // Packet position and held decision
    always_ff @(posedge core_clk) begin
        if (rst) begin
            sop      <= 1'b1;
            pkt_port <= '0;
            pkt_drop <= 1'b0;
        end else if (take) begin
            sop <= out_last;
            if (sop) begin
                pkt_port <= in_word.hdr.egr_port;
                pkt_drop <= hdr_drop;
            end
        end
    end

    ////////////////////
    // Egress registers

    always_ff @(posedge core_clk) begin
        if (rst) begin
            egr_valid <= '0;
        end else begin
            for (int j = 0; j < router_pkg::NUM_PORTS; j++) begin
                if (!egr_valid[j] || egr_ready[j]) begin
                    egr_valid[j] <= take && !cur_drop && (cur_port == j);
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        for (int j = 0; j < router_pkg::NUM_PORTS; j++) begin
            if (take && !cur_drop && (cur_port == j)) begin
                egr_data[j] <= sop ? hdr_word.raw : in_word.raw;
                egr_last[j] <= out_last;
                egr_src[j]  <= out_src;
            end
        end
    end

    // Counted when the last beat leaves the buffer
    always_ff @(posedge core_clk) begin
        if (rst || cnt_clear) begin
            egr_pkt_cnt  <= '0;
            egr_drop_cnt <= '0;
        end else if (take && out_last) begin
            if (cur_drop) begin
                egr_drop_cnt[cur_port] <= egr_drop_cnt[cur_port] + 1'b1;
            end else begin
                egr_pkt_cnt[cur_port] <= egr_pkt_cnt[cur_port] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/router_top.sv
/* Router core on a single clock. Egress enables are static levels. */

`timescale 1ns/1ps
`default_nettype none

module router_top (
    input  wire                              core_clk,
    input  wire                              rst,

    input  wire  [router_pkg::NUM_PORTS-1:0] ing_valid,
    input  wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::DATA_W-1:0]    ing_data,
    input  wire  [router_pkg::NUM_PORTS-1:0] ing_last,
    output wire  [router_pkg::NUM_PORTS-1:0] ing_ready,

    output wire  [router_pkg::NUM_PORTS-1:0] egr_valid,
    output wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::DATA_W-1:0]    egr_data,
    output wire  [router_pkg::NUM_PORTS-1:0] egr_last,
    output wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::PORT_W-1:0]    egr_src,
    input  wire  [router_pkg::NUM_PORTS-1:0] egr_ready,

    input  wire  [router_pkg::NUM_PORTS-1:0] egr_port_enable,
    input  wire                              cnt_clear,
    output wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::CNT_W-1:0]     ing_pkt_cnt,
    output wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::CNT_W-1:0]     egr_pkt_cnt,
    output wire  [router_pkg::NUM_PORTS-1:0]
                 [router_pkg::CNT_W-1:0]     egr_drop_cnt
);

    // Ingress to buffer
    logic                          in_valid;
    logic [router_pkg::DATA_W-1:0] in_data;
    logic                          in_last;
    logic [router_pkg::PORT_W-1:0] in_src;
    logic                          in_ready;

    // Buffer to egress
    logic                          out_valid;
    logic [router_pkg::DATA_W-1:0] out_data;
    logic                          out_last;
    logic [router_pkg::PORT_W-1:0] out_src;
    logic                          out_ready;

    router_ingress ingress (
        .core_clk    ( core_clk    ),
        .rst         ( rst         ),
        .ing_valid   ( ing_valid   ),
        .ing_data    ( ing_data    ),
        .ing_last    ( ing_last    ),
        .ing_ready   ( ing_ready   ),
        .in_valid    ( in_valid    ),
        .in_data     ( in_data     ),
        .in_last     ( in_last     ),
        .in_src      ( in_src      ),
        .in_ready    ( in_ready    ),
        .cnt_clear   ( cnt_clear   ),
        .ing_pkt_cnt ( ing_pkt_cnt )
    );

    router_pkt_buffer pkt_buffer (
        .core_clk  ( core_clk  ),
        .rst       ( rst       ),
        .in_valid  ( in_valid  ),
        .in_data   ( in_data   ),
        .in_last   ( in_last   ),
        .in_src    ( in_src    ),
        .in_ready  ( in_ready  ),
        .out_valid ( out_valid ),
        .out_data  ( out_data  ),
        .out_last  ( out_last  ),
        .out_src   ( out_src   ),
        .out_ready ( out_ready )
    );

    router_egress egress (
        .core_clk        ( core_clk        ),
        .rst             ( rst             ),
        .out_valid       ( out_valid       ),
        .out_data        ( out_data        ),
        .out_last        ( out_last        ),
        .out_src         ( out_src         ),
        .out_ready       ( out_ready       ),
        .egr_valid       ( egr_valid       ),
        .egr_data        ( egr_data        ),
        .egr_last        ( egr_last        ),
        .egr_src         ( egr_src         ),
        .egr_ready       ( egr_ready       ),
        .egr_port_enable ( egr_port_enable ),
        .cnt_clear       ( cnt_clear       ),
        .egr_pkt_cnt     ( egr_pkt_cnt     ),
        .egr_drop_cnt    ( egr_drop_cnt    )
    );

endmodule

`default_nettype wire

// File: sim/router_chk.sv
/* Stream handshake assertions, bound into router_top. Only 32-bit data and
   two ports are covered. */

`timescale 1ns/1ps
`default_nettype none

module router_chk (
    input wire                                     core_clk,
    input wire                                     rst,
    input wire [router_pkg::NUM_PORTS-1:0]         egr_valid,
    input wire [router_pkg::NUM_PORTS-1:0]         egr_ready,
    input wire [router_pkg::NUM_PORTS-1:0]
               [router_pkg::DATA_W-1:0]            egr_data,
    input wire [router_pkg::NUM_PORTS-1:0]
               [router_pkg::PORT_W-1:0]            egr_src,
    input wire [router_pkg::NUM_PORTS-1:0]         ing_ready,
    input wire                                     in_valid,
    input wire                                     out_valid
);

    // Stalled beat stays put
    for (genvar j = 0; j < router_pkg::NUM_PORTS; j++) begin : g_hold
        assert property (@(posedge core_clk) disable iff (rst)
            egr_valid[j] && !egr_ready[j] |=> egr_valid[j] && $stable(egr_data[j]))
            else $error("egress port %0d dropped or changed a stalled beat", j);
    end

    // Same beat never presented on both ports
    assert property (@(posedge core_clk) disable iff (rst)
        !(&egr_valid && egr_src[0] == egr_src[1] && egr_data[0] == egr_data[1]))
        else $error("one packet steered to both egress ports");

    // Valids cleared by reset
    assert property (@(posedge core_clk)
        rst |=> egr_valid == '0 && ing_ready == '0 && !in_valid && !out_valid)
        else $error("valid high after a reset cycle");

endmodule

bind router_top router_chk chk (
    .core_clk  ( core_clk  ),
    .rst       ( rst       ),
    .egr_valid ( egr_valid ),
    .egr_ready ( egr_ready ),
    .egr_data  ( egr_data  ),
    .egr_src   ( egr_src   ),
    .ing_ready ( ing_ready ),
    .in_valid  ( in_valid  ),
    .out_valid ( out_valid )
);

`default_nettype wire

// File: sim/router_tb.sv
/* Reads beats and expected results from sim/router_stim.txt, run from the project root.
   Egress port enables are static for the whole run and come from the P line. */

`timescale 1ns/1ps
`default_nettype none

module router_tb;

    logic                  core_clk;
    logic                  rst;
    logic [1:0]            ing_valid;
    logic [1:0][31:0]      ing_data;
    logic [1:0]            ing_last;
    logic [1:0]            ing_ready;
    logic [1:0]            egr_valid;
    logic [1:0][31:0]      egr_data;
    logic [1:0]            egr_last;
    logic [1:0][0:0]       egr_src;
    logic [1:0]            egr_ready;
    logic [1:0]            egr_port_enable;
    logic                  cnt_clear;
    logic [1:0][15:0]      ing_pkt_cnt;
    logic [1:0][15:0]      egr_pkt_cnt;
    logic [1:0][15:0]      egr_drop_cnt;

    // Ingress beats are {last, data}, expected egress beats {src, last, data}
    logic [32:0]           ing_q [2][$];
    logic [33:0]           exp_q [2][$];
    int                    cnt_exp [6];
    int                    n_ing;
    int                    exp_total;
    int                    rx_count;
    int                    drivers_done;
    int                    errors;
    bit                    loaded;
    bit                    started;
    bit                    saw_stall;
    // Port has accepted beats of a packet but not yet its last one
    bit                    in_pkt [2];
    integer                seed;
    logic [33:0]           got;

    router_top uut (
        .core_clk        ( core_clk        ),
        .rst             ( rst             ),
        .ing_valid       ( ing_valid       ),
        .ing_data        ( ing_data        ),
        .ing_last        ( ing_last        ),
        .ing_ready       ( ing_ready       ),
        .egr_valid       ( egr_valid       ),
        .egr_data        ( egr_data        ),
        .egr_last        ( egr_last        ),
        .egr_src         ( egr_src         ),
        .egr_ready       ( egr_ready       ),
        .egr_port_enable ( egr_port_enable ),
        .cnt_clear       ( cnt_clear       ),
        .ing_pkt_cnt     ( ing_pkt_cnt     ),
        .egr_pkt_cnt     ( egr_pkt_cnt     ),
        .egr_drop_cnt    ( egr_drop_cnt    )
    );

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    ////////////////////
    // Checking helpers

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
            errors++;
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic load_stim();
        integer      fd;
        string       line;
        int          p;
        int          l;
        int          s;
        logic [31:0] d;
        logic [31:0] en;
        fd = $fopen("sim/router_stim.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open sim/router_stim.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            case (line[0])
                "I": begin
                    void'($sscanf(line, "I %d %h %d", p, d, l));
                    ing_q[p].push_back({l[0], d});
                    n_ing++;
                end
                "E": begin
                    void'($sscanf(line, "E %d %h %d %d", p, d, l, s));
                    exp_q[p].push_back({s[0], l[0], d});
                    exp_total++;
                end
                "C": void'($sscanf(line, "C %d %d %d %d %d %d", cnt_exp[0], cnt_exp[1],
                                   cnt_exp[2], cnt_exp[3], cnt_exp[4], cnt_exp[5]));
                "P": begin
                    void'($sscanf(line, "P %h", en));
                    egr_port_enable = en[1:0];
                end
                default: report_failure("unknown line type in stim file");
            endcase
        end
        $fclose(fd);
    endtask

    // One ingress port, beats held until ready
    task automatic drive_port(input int p);
        logic [32:0] beat;
        wait (started);
        while (ing_q[p].size() > 0) begin
            beat         = ing_q[p].pop_front();
            ing_valid[p] = 1'b1;
            ing_last[p]  = beat[32];
            ing_data[p]  = beat[31:0];
            @(posedge core_clk);
            while (!ing_ready[p]) begin
                @(posedge core_clk);
            end
            #1;
        end
        ing_valid[p] = 1'b0;
        drivers_done++;
    endtask

    ////////////////////
    // Stimulus processes

    initial drive_port(0);
    initial drive_port(1);

    // Egress held off at first so the buffer fills, then random
    initial begin
        logic [31:0] rnd;
        wait (started);
        repeat (40) @(posedge core_clk);
        forever begin
            @(posedge core_clk);
            #1;
            rnd       = $random(seed);
            egr_ready = rnd[1:0];
        end
    end

    // Egress monitor
    always @(posedge core_clk) begin
        if (!rst && started) begin
            // Mid-packet port held off while the buffer is full
            for (int i = 0; i < 2; i++) begin
                if (uut.pkt_buffer.full && in_pkt[i] && ing_valid[i] && !ing_ready[i]) begin
                    saw_stall = 1'b1;
                end
                if (ing_valid[i] && ing_ready[i]) begin
                    in_pkt[i] = !ing_last[i];
                end
            end
            for (int j = 0; j < 2; j++) begin
                if (egr_valid[j] && egr_ready[j]) begin
                    if (exp_q[j].size() == 0) begin
                        report_failure($sformatf("unexpected beat on egress port %0d", j));
                    end else begin
                        got = exp_q[j].pop_front();
                        check_value(egr_data[j], got[31:0], $sformatf("data port %0d", j));
                        check_value(32'(egr_last[j]), 32'(got[32]),
                                    $sformatf("last port %0d", j));
                        check_value(32'(egr_src[j]), 32'(got[33]),
                                    $sformatf("src port %0d", j));
                        rx_count++;
                    end
                end
            end
        end
    end

    // Watchdog
    initial begin
        int limit;
        wait (loaded);
        limit = 40 * n_ing + 200;
        repeat (limit) @(posedge core_clk);
        $display("ERROR: timeout after %0d cycles, egress traffic did not complete", limit);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    ////////////////////
    // Main sequence

    initial begin
        rst             = 1'b1;
        ing_valid       = '0;
        ing_data        = '0;
        ing_last        = '0;
        egr_ready       = '0;
        egr_port_enable = 2'b11;
        cnt_clear       = 1'b0;
        seed            = 87;
        load_stim();
        loaded = 1'b1;
        repeat (5) @(posedge core_clk);
        #1;
        rst     = 1'b0;
        started = 1'b1;

        // Drained when every beat arrived and the pipeline is empty
        while (!(rx_count == exp_total && drivers_done == 2 && !uut.in_valid &&
                 !uut.out_valid && egr_valid == 2'b00)) begin
            @(posedge core_clk);
        end
        @(posedge core_clk);
        #1;

        check_value(32'(ing_pkt_cnt[0]), cnt_exp[0], "ing_pkt_cnt[0]");
        check_value(32'(ing_pkt_cnt[1]), cnt_exp[1], "ing_pkt_cnt[1]");
        check_value(32'(egr_pkt_cnt[0]), cnt_exp[2], "egr_pkt_cnt[0]");
        check_value(32'(egr_pkt_cnt[1]), cnt_exp[3], "egr_pkt_cnt[1]");
        check_value(32'(egr_drop_cnt[0]), cnt_exp[4], "egr_drop_cnt[0]");
        check_value(32'(egr_drop_cnt[1]), cnt_exp[5], "egr_drop_cnt[1]");
        check_value(32'(saw_stall), 1, "ing_ready low while buffer full");

        // Clear pulse, counters zero one cycle later
        @(posedge core_clk);
        #1;
        cnt_clear = 1'b1;
        @(posedge core_clk);
        #1;
        cnt_clear = 1'b0;
        check_value(32'({ing_pkt_cnt[0], ing_pkt_cnt[1]}), 0, "ing_pkt_cnt after clear");
        check_value(32'({egr_pkt_cnt[0], egr_pkt_cnt[1]}), 0, "egr_pkt_cnt after clear");
        check_value(32'({egr_drop_cnt[0], egr_drop_cnt[1]}), 0, "egr_drop_cnt after clear");

        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// File: sim/router_stim.txt
# I <ingress port> <data hex> <last> | E <egress port> <data hex> <last> <src tag>
# C <ing cnt 0> <ing cnt 1> <egr cnt 0> <egr cnt 1> <drop cnt 0> <drop cnt 1> | P <enable hex>
P 1
# Ingress port 0: A fwd, C ttl zero, E fwd, G fwd
I 0 05020001 0
I 0 a0000001 0
I 0 a0000002 1
I 0 00010003 0
I 0 c0000001 1
I 0 02040005 0
I 0 e0000001 0
I 0 e0000002 0
I 0 e0000003 0
I 0 e0000004 1
I 0 03010007 0
I 0 70000001 1
# Ingress port 1: B and H to disabled port 1, D and F fwd
I 1 83010002 0
I 1 b0000001 1
I 1 07030004 0
I 1 d0000001 0
I 1 d0000002 0
I 1 d0000003 1
I 1 01020006 0
I 1 f0000001 0
I 1 f0000002 1
I 1 81010008 0
I 1 80000001 1
# Round-robin order A B C D E F G H, port 0 gets A D E F G
E 0 04020001 0 0
E 0 a0000001 0 0
E 0 a0000002 1 0
E 0 06030004 0 1
E 0 d0000001 0 1
E 0 d0000002 0 1
E 0 d0000003 1 1
E 0 01040005 0 0
E 0 e0000001 0 0
E 0 e0000002 0 0
E 0 e0000003 0 0
E 0 e0000004 1 0
E 0 00020006 0 1
E 0 f0000001 0 1
E 0 f0000002 1 1
E 0 02010007 0 0
E 0 70000001 1 0
C 4 4 5 0 1 2

// File: tb.f
logic/router_pkg.sv
logic/router_ingress.sv
logic/router_pkt_buffer.sv
logic/router_egress.sv
logic/router_top.sv
sim/router_chk.sv
sim/router_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module router_tb -Mdir obj_dir -f tb.f

run: compile
	./obj_dir/Vrouter_tb

clean:
	rm -rf obj_dir
